/* rtl/btb_pkg.sv */
// Fixed 2-way, 64-set geometry; changing widths here also changes the entry layout used by every RTL file

package btb_pkg;

   // --------------------------------------------------
   // Geometry
   // --------------------------------------------------

   // 64 sets addressed by a 6-bit index
   localparam int unsigned BTB_INDEX_W   = 6;
   localparam int unsigned BTB_NUM_SETS  = 1 << BTB_INDEX_W;

   // Stored tag and target offset widths
   localparam int unsigned BTB_TAG_W     = 9;
   localparam int unsigned BTB_TOFFSET_W = 12;

   // Two ways per set, two slots per fetch group
   localparam int unsigned BTB_NUM_WAYS  = 2;
   localparam int unsigned BTB_NUM_SLOTS = 2;

   // --------------------------------------------------
   // Types
   // --------------------------------------------------

   typedef logic [BTB_INDEX_W-1:0] btb_index_t;
   typedef logic [BTB_TAG_W-1:0]   btb_tag_t;

   // Way and slot numbers, one bit each for the 2x2 arrangement
   typedef logic                   btb_way_t;
   typedef logic                   btb_slot_t;

   // One stored branch, 23 bits
   // boff marks the upper half of the fetch group,
   // pc4 marks a 4-byte branch instruction
   typedef struct packed {
      btb_tag_t                   tag;
      logic [BTB_TOFFSET_W-1:0]   toffset;
      logic                       boff;
      logic                       pc4;
   } btb_entry_t;

endpackage

/* rtl/btb_if.sv */
// Lookup and update buses between the request stage and the ways; no handshake, no back-pressure

`timescale 1ns/100ps

// --------------------------------------------------
// Lookup bus
// --------------------------------------------------
interface btb_rd_if;
   import btb_pkg::*;

   // Current-cycle lookup, used for the synchronous array read
   logic          rd_en;
   btb_index_t    rd_index;

   // Registered strobe and tag for the compare in the next cycle
   logic          rd_en_q;
   btb_tag_t      rd_tag_q;

   modport req (
      output rd_en,
      output rd_index,
      output rd_en_q,
      output rd_tag_q
   );

   modport way (
      input  rd_en,
      input  rd_index,
      input  rd_en_q,
      input  rd_tag_q
   );
endinterface

// --------------------------------------------------
// Update bus
// --------------------------------------------------
interface btb_wr_if;
   import btb_pkg::*;

   // Per-way enables, data only when the entry becomes valid
   logic [BTB_NUM_WAYS-1:0]  data_we;
   logic [BTB_NUM_WAYS-1:0]  valid_we;
   logic                     set_valid;
   btb_index_t               wr_index;
   btb_entry_t               wr_entry;

   modport req (
      output data_we,
      output valid_we,
      output set_valid,
      output wr_index,
      output wr_entry
   );

   modport way (
      input  data_we,
      input  valid_we,
      input  set_valid,
      input  wr_index,
      input  wr_entry
   );
endinterface

/* rtl/btb_req_stage.sv */
// Registers the lookup strobe and tag for one cycle; update decode is combinational and takes effect at the next edge

`timescale 1ns/100ps

module btb_req_stage (
   input  logic                                clk,
   input  logic                                rst_n,

   input  logic                                rd_en,
   input  btb_pkg::btb_index_t                 rd_index,
   input  btb_pkg::btb_tag_t                   rd_tag,

   input  logic                                wr_en,
   input  btb_pkg::btb_index_t                 wr_index,
   input  btb_pkg::btb_way_t                   wr_way,
   input  logic                                wr_valid,
   input  btb_pkg::btb_tag_t                   wr_tag,
   input  logic [btb_pkg::BTB_TOFFSET_W-1:0]   wr_toffset,
   input  logic                                wr_boff,
   input  logic                                wr_pc4,

   btb_rd_if.req                               rd,
   btb_wr_if.req                               wr
);
   import btb_pkg::*;

   // --------------------------------------------------
   // Lookup side
   // --------------------------------------------------

   // Index goes straight to the arrays for the synchronous read
   assign rd.rd_en    = rd_en;
   assign rd.rd_index = rd_index;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd.rd_en_q <= 1'b0;
      end else begin
         rd.rd_en_q <= rd_en;
      end
   end

   // Tag is only needed in the cycle after a lookup
   always_ff @(posedge clk) begin
      if (rd_en) begin
         rd.rd_tag_q <= rd_tag;
      end
   end

   // --------------------------------------------------
   // Update side
   // --------------------------------------------------

   assign wr.wr_index  = wr_index;
   assign wr.set_valid = wr_valid;
   assign wr.wr_entry  = '{tag: wr_tag, toffset: wr_toffset, boff: wr_boff, pc4: wr_pc4};

   // Invalidate touches only the valid bit, stored data is kept
   always_comb begin
      for (int w = 0; w < BTB_NUM_WAYS; w++) begin
         wr.valid_we[w] = wr_en & (wr_way == btb_way_t'(w));
         wr.data_we[w]  = wr_en & (wr_way == btb_way_t'(w)) & wr_valid;
      end
   end

endmodule

/* rtl/btb_way_store.sv */
// One way of 64 sets; read data is registered at the lookup edge and compared in the following cycle

`timescale 1ns/100ps

module btb_way_store #(
   parameter int unsigned WAY_ID = 0
) (
   input  logic                 clk,
   input  logic                 rst_n,

   btb_rd_if.way                rd,
   btb_wr_if.way                wr,

   output logic                 hit,
   output btb_pkg::btb_entry_t  entry
);
   import btb_pkg::*;

   // Entry array and per-set valid bits
   btb_entry_t                mem [BTB_NUM_SETS];
   logic [BTB_NUM_SETS-1:0]   valid;

   // Read stage
   btb_entry_t                rd_entry_q;
   logic                      rd_valid_q;

   // --------------------------------------------------
   // Data array
   // --------------------------------------------------

   // A read at the same edge as a write returns the old entry
   always_ff @(posedge clk) begin
      if (wr.data_we[WAY_ID]) begin
         mem[wr.wr_index] <= wr.wr_entry;
      end
      if (rd.rd_en) begin
         rd_entry_q <= mem[rd.rd_index];
      end
   end

   // --------------------------------------------------
   // Valid bits
   // --------------------------------------------------

   // Set or cleared in the same cycle as the data write
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid <= '0;
      end else if (wr.valid_we[WAY_ID]) begin
         valid[wr.wr_index] <= wr.set_valid;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_valid_q <= 1'b0;
      end else if (rd.rd_en) begin
         rd_valid_q <= valid[rd.rd_index];
      end
   end

   // --------------------------------------------------
   // Tag compare
   // --------------------------------------------------

   // No lookup last cycle means no hit, whatever the held read data
   assign hit   = rd_valid_q & rd.rd_en_q & (rd_entry_q.tag == rd.rd_tag_q);
   assign entry = rd_entry_q;

endmodule

/* rtl/btb_slot_order.sv */
// Combinational only; when both ways target one slot, way 0 is reported and way 1 is dropped

`timescale 1ns/100ps

module btb_slot_order (
   input  logic [btb_pkg::BTB_NUM_WAYS-1:0]     way_hit,
   input  btb_pkg::btb_entry_t                  way_entry [btb_pkg::BTB_NUM_WAYS],

   output logic [btb_pkg::BTB_NUM_SLOTS-1:0]    slot_hit,
   output btb_pkg::btb_way_t                    slot0_way,
   output btb_pkg::btb_way_t                    slot1_way,
   output logic [btb_pkg::BTB_TOFFSET_W-1:0]    slot0_toffset,
   output logic [btb_pkg::BTB_TOFFSET_W-1:0]    slot1_toffset
);
   import btb_pkg::*;

   btb_way_t                   slot_way [BTB_NUM_SLOTS];
   logic [BTB_TOFFSET_W-1:0]   slot_toffset [BTB_NUM_SLOTS];

   // --------------------------------------------------
   // Way to slot mapping
   // --------------------------------------------------

   // Slot of a hit is boff XOR pc4.
   // Highest way first so that way 0 overwrites on a tie
   always_comb begin
      btb_slot_t slot;

      slot     = '0;
      slot_hit = '0;
      for (int s = 0; s < BTB_NUM_SLOTS; s++) begin
         slot_way[s]     = '0;
         slot_toffset[s] = '0;
      end

      for (int w = BTB_NUM_WAYS - 1; w >= 0; w--) begin
         if (way_hit[w]) begin
            slot                = btb_slot_t'(way_entry[w].boff ^ way_entry[w].pc4);
            slot_hit[slot]      = 1'b1;
            slot_way[slot]      = btb_way_t'(w);
            slot_toffset[slot]  = way_entry[w].toffset;
         end
      end
   end

   // --------------------------------------------------
   // Per-slot outputs
   // --------------------------------------------------

   // Fields stay zero for a slot without a hit
   assign slot0_way     = slot_way[0];
   assign slot1_way     = slot_way[1];
   assign slot0_toffset = slot_toffset[0];
   assign slot1_toffset = slot_toffset[1];

endmodule

/* rtl/btb_top.sv */
// Two-way BTB with one-cycle lookup latency; updates are seen by lookups from the next edge on, no back-pressure

`timescale 1ns/100ps

module btb_top (
   input  logic                                clk,
   input  logic                                rst_n,

   // Lookup
   input  logic                                rd_en,
   input  btb_pkg::btb_index_t                 rd_index,
   input  btb_pkg::btb_tag_t                   rd_tag,

   // Update
   input  logic                                wr_en,
   input  btb_pkg::btb_index_t                 wr_index,
   input  btb_pkg::btb_way_t                   wr_way,
   input  logic                                wr_valid,
   input  btb_pkg::btb_tag_t                   wr_tag,
   input  logic [btb_pkg::BTB_TOFFSET_W-1:0]   wr_toffset,
   input  logic                                wr_boff,
   input  logic                                wr_pc4,

   // Result, one cycle after the lookup
   output logic [btb_pkg::BTB_NUM_SLOTS-1:0]   slot_hit,
   output btb_pkg::btb_way_t                   slot0_way,
   output btb_pkg::btb_way_t                   slot1_way,
   output logic [btb_pkg::BTB_TOFFSET_W-1:0]   slot0_toffset,
   output logic [btb_pkg::BTB_TOFFSET_W-1:0]   slot1_toffset
);
   import btb_pkg::*;

   btb_rd_if  rd_bus ();
   btb_wr_if  wr_bus ();

   logic [BTB_NUM_WAYS-1:0]  way_hit;
   btb_entry_t               way_entry [BTB_NUM_WAYS];

   // --------------------------------------------------
   // Request stage
   // --------------------------------------------------
   btb_req_stage u_req_stage (
      .clk        (clk),
      .rst_n      (rst_n),
      .rd_en      (rd_en),
      .rd_index   (rd_index),
      .rd_tag     (rd_tag),
      .wr_en      (wr_en),
      .wr_index   (wr_index),
      .wr_way     (wr_way),
      .wr_valid   (wr_valid),
      .wr_tag     (wr_tag),
      .wr_toffset (wr_toffset),
      .wr_boff    (wr_boff),
      .wr_pc4     (wr_pc4),
      .rd         (rd_bus.req),
      .wr         (wr_bus.req)
   );

   // --------------------------------------------------
   // Ways
   // --------------------------------------------------
   for (genvar w = 0; w < BTB_NUM_WAYS; w++) begin : g_way
      btb_way_store #(
         .WAY_ID (w)
      ) u_way_store (
         .clk   (clk),
         .rst_n (rst_n),
         .rd    (rd_bus.way),
         .wr    (wr_bus.way),
         .hit   (way_hit[w]),
         .entry (way_entry[w])
      );
   end

   // --------------------------------------------------
   // Slot ordering
   // --------------------------------------------------
   btb_slot_order u_slot_order (
      .way_hit       (way_hit),
      .way_entry     (way_entry),
      .slot_hit      (slot_hit),
      .slot0_way     (slot0_way),
      .slot1_way     (slot1_way),
      .slot0_toffset (slot0_toffset),
      .slot1_toffset (slot1_toffset)
   );

endmodule

/* testbench/btb_properties.sv */
// Watches only the top-level ports; fail_count is read by the testbench at the end of the run

`timescale 1ns/100ps

module btb_properties (
   input  logic                                clk,
   input  logic                                rst_n,
   input  logic                                rd_en,
   input  logic [btb_pkg::BTB_NUM_SLOTS-1:0]   slot_hit,
   input  btb_pkg::btb_way_t                   slot0_way,
   input  btb_pkg::btb_way_t                   slot1_way,
   input  logic [btb_pkg::BTB_TOFFSET_W-1:0]   slot0_toffset,
   input  logic [btb_pkg::BTB_TOFFSET_W-1:0]   slot1_toffset
);

   int unsigned fail_count = 0;

   // No lookup, no result in the next cycle
   a_idle_no_hit: assert property (@(posedge clk) disable iff (!rst_n)
      !rd_en |=> slot_hit == '0)
      else begin
         fail_count++;
         $error("slot_hit set one cycle after a cycle without rd_en");
      end

   a_reset_no_hit: assert property (@(posedge clk) !rst_n |-> slot_hit == '0)
      else begin
         fail_count++;
         $error("slot_hit set during reset");
      end

   // --------------------------------------------------
   // Fields of a slot without a hit
   // --------------------------------------------------
   a_slot0_zero: assert property (@(posedge clk) disable iff (!rst_n)
      !slot_hit[0] |-> (slot0_way == 1'b0 && slot0_toffset == '0))
      else begin
         fail_count++;
         $error("slot 0 fields non-zero without a slot 0 hit");
      end

   a_slot1_zero: assert property (@(posedge clk) disable iff (!rst_n)
      !slot_hit[1] |-> (slot1_way == 1'b0 && slot1_toffset == '0))
      else begin
         fail_count++;
         $error("slot 1 fields non-zero without a slot 1 hit");
      end

endmodule

bind btb_top btb_properties u_properties (.*);

/* testbench/btb_tb.sv */
// Reads testbench/btb_vectors.txt from the project root; each lookup is checked one cycle later

`timescale 1ns/100ps

module btb_tb;
   import btb_pkg::*;

   localparam int unsigned HALF_PERIOD   = 4;
   localparam int unsigned RESET_CYCLES  = 16;
   localparam int unsigned RESET_TIMEOUT = 64;
   localparam int unsigned LINE_LIMIT    = 1000;
   localparam int unsigned DRAIN_TIMEOUT = 8;
   localparam logic [31:0] SEED          = 32'h4741;

   logic                              clk;
   logic                              rst_n;
   logic                              rd_en;
   btb_index_t                        rd_index;
   btb_tag_t                          rd_tag;
   logic                              wr_en;
   btb_index_t                        wr_index;
   btb_way_t                          wr_way;
   logic                              wr_valid;
   btb_tag_t                          wr_tag;
   logic [BTB_TOFFSET_W-1:0]          wr_toffset;
   logic                              wr_boff;
   logic                              wr_pc4;
   logic [BTB_NUM_SLOTS-1:0]          slot_hit;
   btb_way_t                          slot0_way;
   btb_way_t                          slot1_way;
   logic [BTB_TOFFSET_W-1:0]          slot0_toffset;
   logic [BTB_TOFFSET_W-1:0]          slot1_toffset;

   // Expected result of one lookup
   typedef struct packed {
      logic [BTB_NUM_SLOTS-1:0]   hit;
      btb_way_t                   way0;
      logic [BTB_TOFFSET_W-1:0]   off0;
      btb_way_t                   way1;
      logic [BTB_TOFFSET_W-1:0]   off1;
   } result_t;

   // Pending check, due right after the edge that samples the lookup
   result_t       exp_q;
   logic          exp_v;
   int unsigned   errors;
   int unsigned   checks;

   btb_top DUT (.*);

   always #HALF_PERIOD clk = ~clk;

   initial begin
      clk   = 1'b0;
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1 rst_n = 1'b1;
   end

   task automatic compare(input string name, input logic [31:0] actual,
                          input logic [31:0] expected);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("error at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
      end
   endtask

   task automatic check_result(input result_t e);
      compare("slot_hit", 32'(slot_hit), 32'(e.hit));
      compare("slot0_way", 32'(slot0_way), 32'(e.way0));
      compare("slot0_toffset", 32'(slot0_toffset), 32'(e.off0));
      compare("slot1_way", 32'(slot1_way), 32'(e.way1));
      compare("slot1_toffset", 32'(slot1_toffset), 32'(e.off1));
   endtask

   // One clock, ending 1 ns after the rising edge where new inputs are driven
   task automatic step();
      @(posedge clk);
      #1;
      if (exp_v) begin
         check_result(exp_q);
      end
      exp_v = 1'b0;
   endtask

   task automatic drive_idle();
      rd_en = 1'b0;
      wr_en = 1'b0;
   endtask

   // --------------------------------------------------
   // Vector file reader and driver
   // --------------------------------------------------
   task automatic run_vectors();
      int            fd;
      string         line;
      int            n;
      logic [7:0]    cmd;
      logic [31:0]   f [7];
      int unsigned   lines;
      int unsigned   idle;
      int unsigned   drain;

      fd = $fopen("testbench/btb_vectors.txt", "r");
      if (fd == 0) begin
         $display("cannot open the vector file testbench/btb_vectors.txt");
         errors++;
         return;
      end
      lines = 0;
      while (!$feof(fd) && lines < LINE_LIMIT) begin
         lines++;
         line = "";
         if ($fgets(line, fd) == 0) begin
            continue;
         end
         cmd = 8'h00;
         n = $sscanf(line, "%s %h %h %h %h %h %h %h", cmd, f[0], f[1], f[2], f[3], f[4],
                     f[5], f[6]);
         if (n == 8 && cmd == "W") begin
            // Random gap before each update
            idle = $urandom % 3;
            repeat (idle) begin
               drive_idle();
               step();
            end
            rd_en      = 1'b0;
            wr_en      = 1'b1;
            wr_index   = btb_index_t'(f[0]);
            wr_way     = f[1][0];
            wr_valid   = f[2][0];
            wr_tag     = btb_tag_t'(f[3]);
            wr_toffset = f[4][BTB_TOFFSET_W-1:0];
            wr_boff    = f[5][0];
            wr_pc4     = f[6][0];
            step();
         end else if (n == 8 && cmd == "R") begin
            wr_en    = 1'b0;
            rd_en    = 1'b1;
            rd_index = btb_index_t'(f[0]);
            rd_tag   = btb_tag_t'(f[1]);
            exp_q    = '{hit: f[2][BTB_NUM_SLOTS-1:0], way0: f[3][0],
                         off0: f[4][BTB_TOFFSET_W-1:0], way1: f[5][0],
                         off1: f[6][BTB_TOFFSET_W-1:0]};
            exp_v    = 1'b1;
            step();
         end else if (n > 0 && cmd != "#") begin
            $display("unreadable line %0d in the vector file: %s", lines, line);
            errors++;
         end
      end
      if (!$feof(fd)) begin
         $display("vector file still not finished after %0d lines", LINE_LIMIT);
         errors++;
      end
      $fclose(fd);

      // Without a lookup the outputs go back to zero
      drive_idle();
      drain = 0;
      do begin
         step();
         drain++;
      end while (slot_hit !== '0 && drain < DRAIN_TIMEOUT);
      if (slot_hit !== '0) begin
         $display("slot_hit did not return to zero after the last lookup");
         errors++;
      end else begin
         check_result('0);
      end
   endtask

   task automatic finish_run();
      errors += DUT.u_properties.fail_count;
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   endtask

   initial begin
      int unsigned wait_cnt;

      rd_en      = 1'b0;
      rd_index   = '0;
      rd_tag     = '0;
      wr_en      = 1'b0;
      wr_index   = '0;
      wr_way     = 1'b0;
      wr_valid   = 1'b0;
      wr_tag     = '0;
      wr_toffset = '0;
      wr_boff    = 1'b0;
      wr_pc4     = 1'b0;
      exp_q      = '0;
      exp_v      = 1'b0;
      errors     = 0;
      checks     = 0;
      void'($urandom(SEED));

      wait_cnt = 0;
      while (rst_n !== 1'b1 && wait_cnt < RESET_TIMEOUT) begin
         @(posedge clk);
         #1;
         wait_cnt++;
      end
      if (rst_n !== 1'b1) begin
         $display("reset was not released within %0d cycles", RESET_TIMEOUT);
         errors++;
      end else begin
         run_vectors();
      end
      finish_run();
   end

endmodule

/* testbench/btb_vectors.txt */
# W index way valid tag toffset boff pc4, all fields hex
# R index tag exp_slot_hit slot0_way slot0_toffset slot1_way slot1_toffset
# Miss after reset
R 05 1a3 0 0 000 0 000
R 3f 000 0 0 000 0 000
# Way 0 entry in slot 0, then a tag mismatch
W 0a 0 1 1a3 123 0 0
R 0a 1a3 1 0 123 0 000
R 0a 1a4 0 0 000 0 000
# Way 0 entry in slot 1
W 0b 0 1 042 7e5 1 0
R 0b 042 2 0 000 0 7e5
# Both ways, one slot each
W 10 0 1 055 aaa 0 0
W 10 1 1 055 bbb 0 1
R 10 055 3 0 aaa 1 bbb
# Both ways in slot 1, way 0 wins
W 20 0 1 077 111 1 0
W 20 1 1 077 222 0 1
R 20 077 2 0 000 0 111
# Way 1 alone in slot 0
W 21 1 1 0ff 333 1 1
R 21 0ff 1 1 333 0 000
# Invalidate, then revalidate with a new offset
W 0a 0 0 000 000 0 0
R 0a 1a3 0 0 000 0 000
W 0a 0 1 1a3 456 0 0
R 0a 1a3 1 0 456 0 000
W 10 1 0 000 000 0 0
R 10 055 1 0 aaa 0 000
# Back-to-back lookups across sets
R 0b 042 2 0 000 0 7e5
R 20 077 2 0 000 0 111
R 05 1a3 0 0 000 0 000
R 21 0ff 1 1 333 0 000
R 0a 1a3 1 0 456 0 000

/* src.f */
rtl/btb_pkg.sv
rtl/btb_if.sv
rtl/btb_req_stage.sv
rtl/btb_way_store.sv
rtl/btb_slot_order.sv
rtl/btb_top.sv
testbench/btb_properties.sv
testbench/btb_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = btb_tb
FILELIST  = src.f
OBJ_DIR   = obj_dir
LOG       = sim.log
SIM_ARGS  = +verilator+error+limit+100
FAIL_MSG  = Done: errors found

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
